// File: source/lsu_pkg.sv
package lsu_pkg;

	localparam int tag_width = 4;
	localparam int data_width = 32;
	localparam int addr_width = 10; // word address, 1024 words
	localparam int imm_width = 16;

	// address generation holds two waiting entries
	localparam int agu_depth = 2;

	// one immediate field, read as an absolute address or a signed offset
	typedef union packed {
		struct packed {
			logic [imm_width-addr_width-1:0] pad;
			logic [addr_width-1:0] addr;
		} abs;
		logic signed [imm_width-1:0] offset;
	} lsu_imm_u;

endpackage

// File: source/lsu_data_mem.sv
`timescale 1ns/1ps

module lsu_data_mem (
	input logic clk,
	input logic we,
	input logic [lsu_pkg::addr_width-1:0] waddr,
	input logic [lsu_pkg::data_width-1:0] wdata,
	input logic [lsu_pkg::addr_width-1:0] raddr,
	output logic [lsu_pkg::data_width-1:0] rdata
);
	localparam int words = 2 ** lsu_pkg::addr_width;

	logic [lsu_pkg::data_width-1:0] mem [words] = '{default: '0};

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr]; // old word on a same-address write
	end

endmodule

// File: source/lsu_agu.sv
`timescale 1ns/1ps

module lsu_agu #(
	parameter int load_depth = 2,
	parameter int store_depth = 4,
	localparam int slot_width = $clog2(load_depth > store_depth ? load_depth : store_depth)
) (
	input logic clk,
	input logic reset,
	input logic issue_accept,
	input logic issue_store,
	input logic issue_absolute,
	input lsu_pkg::lsu_imm_u issue_imm,
	input logic issue_base_ready,
	input logic [lsu_pkg::tag_width-1:0] issue_base_tag,
	input logic [lsu_pkg::data_width-1:0] issue_base_data,
	input logic [slot_width-1:0] load_next_slot,
	input logic [slot_width-1:0] store_next_slot,
	input logic load_pop,
	input logic commit,
	input logic cdb_valid,
	input logic [lsu_pkg::tag_width-1:0] cdb_tag,
	input logic [lsu_pkg::data_width-1:0] cdb_data,
	output logic agu_full,
	output logic agu_write,
	output logic agu_is_store,
	output logic [slot_width-1:0] agu_slot,
	output logic [lsu_pkg::addr_width-1:0] agu_addr
);
	localparam int depth = lsu_pkg::agu_depth;
	localparam int dw = lsu_pkg::data_width;
	localparam int iw = lsu_pkg::imm_width;

	logic ent_valid [depth];
	logic ent_store [depth];
	logic [slot_width-1:0] ent_slot [depth];
	logic [lsu_pkg::tag_width-1:0] ent_tag [depth];
	logic ent_ready [depth];
	logic [dw-1:0] ent_base [depth];
	lsu_pkg::lsu_imm_u ent_imm [depth];

	logic upd_ready [depth];
	logic [dw-1:0] upd_base [depth];
	logic [slot_width-1:0] upd_slot [depth];

	logic push;
	logic new_ready;
	logic [dw-1:0] new_base;
	logic dispatch;
	int sel;
	int src [depth];
	logic take_new [depth];
	logic nxt_valid [depth];
	logic [iw-1:0] sel_off;
	logic [dw-1:0] sum;

	assign push = issue_accept && !issue_absolute;
	assign new_ready = issue_base_ready || (cdb_valid && cdb_tag == issue_base_tag);
	assign new_base = issue_base_ready ? issue_base_data : cdb_data;

	// wakeup and slot tracking as the queues pop
	always_comb begin
		for (int j = 0; j < depth; j++) begin
			upd_ready[j] = ent_ready[j] || (cdb_valid && cdb_tag == ent_tag[j]);
			upd_base[j] = ent_ready[j] ? ent_base[j] : cdb_data;
			upd_slot[j] = ent_slot[j] - slot_width'(ent_store[j] ? commit : load_pop);
		end
	end

	always_comb begin
		dispatch = 1'b0;
		sel = 0;
		for (int j = depth - 1; j >= 0; j--) begin
			if (ent_valid[j] && ent_ready[j]) begin // lowest ready entry wins
				dispatch = 1'b1;
				sel = j;
			end
		end
	end

	assign sel_off = ent_imm[sel].offset;
	assign sum = ent_base[sel] + {{(dw - iw){sel_off[iw-1]}}, sel_off};

	assign agu_write = dispatch;
	assign agu_is_store = ent_store[sel];
	assign agu_slot = ent_slot[sel];
	assign agu_addr = sum[lsu_pkg::addr_width-1:0];
	assign agu_full = ent_valid[depth-1] && !dispatch; // no room this cycle

	// compact the survivors toward entry 0, new one goes behind
	always_comb begin
		int n;
		n = 0;
		for (int d = 0; d < depth; d++) begin
			src[d] = d;
			take_new[d] = 1'b0;
			nxt_valid[d] = 1'b0;
		end
		for (int j = 0; j < depth; j++) begin
			if (ent_valid[j] && !(dispatch && sel == j)) begin
				src[n] = j;
				nxt_valid[n] = 1'b1;
				n = n + 1;
			end
		end
		if (push && n < depth) begin
			take_new[n] = 1'b1;
			nxt_valid[n] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		for (int d = 0; d < depth; d++) begin
			if (reset) begin
				ent_valid[d] <= 1'b0;
			end else begin
				ent_valid[d] <= nxt_valid[d];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int d = 0; d < depth; d++) begin
			if (take_new[d]) begin
				ent_store[d] <= issue_store;
				ent_slot[d] <= issue_store ? store_next_slot : load_next_slot;
				ent_tag[d] <= issue_base_tag;
				ent_ready[d] <= new_ready;
				ent_base[d] <= new_base;
				ent_imm[d] <= issue_imm;
			end else begin
				ent_store[d] <= ent_store[src[d]];
				ent_slot[d] <= upd_slot[src[d]];
				ent_tag[d] <= ent_tag[src[d]];
				ent_ready[d] <= upd_ready[src[d]];
				ent_base[d] <= upd_base[src[d]];
				ent_imm[d] <= ent_imm[src[d]];
			end
		end
	end

endmodule

// File: source/lsu_load_queue.sv
`timescale 1ns/1ps

module lsu_load_queue #(
	parameter int load_depth = 2,
	parameter int store_depth = 4,
	localparam int slot_width = $clog2(load_depth > store_depth ? load_depth : store_depth),
	localparam int count_width = $clog2(load_depth + 1),
	localparam int older_width = $clog2(store_depth + 1)
) (
	input logic clk,
	input logic reset,
	input logic issue_accept,
	input logic issue_store,
	input logic issue_absolute,
	input lsu_pkg::lsu_imm_u issue_imm,
	input logic [lsu_pkg::tag_width-1:0] issue_tag,
	input logic [older_width-1:0] store_count,
	input logic agu_write,
	input logic agu_is_store,
	input logic [slot_width-1:0] agu_slot,
	input logic [lsu_pkg::addr_width-1:0] agu_addr,
	input logic older_known,
	input logic fwd_hit,
	input logic [lsu_pkg::data_width-1:0] fwd_data,
	input logic commit,
	input logic [lsu_pkg::data_width-1:0] mem_rdata,
	input logic load_ready,
	output logic load_full,
	output logic [slot_width-1:0] load_next_slot,
	output logic load_pop,
	output logic [lsu_pkg::addr_width-1:0] head_addr,
	output logic [older_width-1:0] head_older,
	output logic load_valid,
	output logic result_valid,
	output logic [lsu_pkg::tag_width-1:0] result_tag,
	output logic [lsu_pkg::data_width-1:0] result_data
);
	logic [count_width-1:0] count;
	logic [count_width-1:0] ins;
	logic push;

	logic [lsu_pkg::tag_width-1:0] tag [load_depth];
	logic [lsu_pkg::addr_width-1:0] addr [load_depth];
	logic addr_valid [load_depth];
	logic [older_width-1:0] older [load_depth]; // stores ahead of this load

	logic [lsu_pkg::addr_width-1:0] upd_addr [load_depth];
	logic upd_addr_valid [load_depth];
	logic [older_width-1:0] upd_older [load_depth];

	logic hit_q;
	logic [lsu_pkg::data_width-1:0] fwd_q;

	assign push = issue_accept && !issue_store;
	assign ins = count - count_width'(load_pop);
	assign load_next_slot = slot_width'(ins);
	assign load_full = count == count_width'(load_depth) && !load_pop;

	assign load_valid = count != '0 && addr_valid[0] && older_known;
	assign load_pop = load_valid && load_ready;
	assign head_addr = addr[0];
	assign head_older = older[0];

	always_comb begin
		logic hit;
		for (int j = 0; j < load_depth; j++) begin
			hit = agu_write && !agu_is_store && agu_slot == slot_width'(j);
			upd_addr_valid[j] = addr_valid[j] || hit;
			upd_addr[j] = hit ? agu_addr : addr[j];
			upd_older[j] = older[j] - older_width'(commit && older[j] != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= ins + count_width'(push);
		end
	end

	// shift toward slot 0 on pop; last slot takes don't-care data
	always_ff @(posedge clk) begin
		for (int j = 0; j < load_depth; j++) begin
			if (push && ins == count_width'(j)) begin
				tag[j] <= issue_tag;
				addr[j] <= issue_imm.abs.addr;
				addr_valid[j] <= issue_absolute;
				older[j] <= store_count - older_width'(commit);
			end else if (load_pop) begin
				tag[j] <= tag[(j + 1) % load_depth];
				addr[j] <= upd_addr[(j + 1) % load_depth];
				addr_valid[j] <= upd_addr_valid[(j + 1) % load_depth];
				older[j] <= upd_older[(j + 1) % load_depth];
			end else begin
				addr[j] <= upd_addr[j];
				addr_valid[j] <= upd_addr_valid[j];
				older[j] <= upd_older[j];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= load_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (load_pop) begin
			result_tag <= tag[0];
			hit_q <= fwd_hit;
			fwd_q <= fwd_data;
		end
	end

	// memory word arrives one cycle after the pop
	assign result_data = hit_q ? fwd_q : mem_rdata;

endmodule

// File: source/lsu_store_queue.sv
`timescale 1ns/1ps

module lsu_store_queue #(
	parameter int store_depth = 4,
	localparam int slot_width = $clog2(store_depth),
	localparam int count_width = $clog2(store_depth + 1)
) (
	input logic clk,
	input logic reset,
	input logic issue_accept,
	input logic issue_store,
	input logic issue_absolute,
	input lsu_pkg::lsu_imm_u issue_imm,
	input logic issue_data_ready,
	input logic [lsu_pkg::tag_width-1:0] issue_data_tag,
	input logic [lsu_pkg::data_width-1:0] issue_data_data,
	input logic cdb_valid,
	input logic [lsu_pkg::tag_width-1:0] cdb_tag,
	input logic [lsu_pkg::data_width-1:0] cdb_data,
	input logic agu_write,
	input logic agu_is_store,
	input logic [slot_width-1:0] agu_slot,
	input logic [lsu_pkg::addr_width-1:0] agu_addr,
	input logic commit,
	input logic [lsu_pkg::addr_width-1:0] head_addr,
	input logic [count_width-1:0] head_older,
	output logic store_full,
	output logic [count_width-1:0] store_count,
	output logic [slot_width-1:0] store_next_slot,
	output logic store_head_done,
	output logic older_known,
	output logic fwd_hit,
	output logic [lsu_pkg::data_width-1:0] fwd_data,
	output logic mem_we,
	output logic [lsu_pkg::addr_width-1:0] mem_waddr,
	output logic [lsu_pkg::data_width-1:0] mem_wdata
);
	localparam int dw = lsu_pkg::data_width;

	logic [count_width-1:0] count;
	logic [count_width-1:0] ins;
	logic push;
	logic new_data_ready;
	logic [dw-1:0] new_data;

	logic [lsu_pkg::addr_width-1:0] addr [store_depth];
	logic addr_valid [store_depth];
	logic [dw-1:0] data [store_depth];
	logic data_valid [store_depth];
	logic [lsu_pkg::tag_width-1:0] tag [store_depth];

	logic [lsu_pkg::addr_width-1:0] upd_addr [store_depth];
	logic upd_addr_valid [store_depth];
	logic [dw-1:0] upd_data [store_depth];
	logic upd_data_valid [store_depth];

	assign push = issue_accept && issue_store;
	assign ins = count - count_width'(commit);
	assign store_next_slot = slot_width'(ins);
	assign store_full = count == count_width'(store_depth) && !commit;
	assign store_count = count;
	assign store_head_done = count != '0 && addr_valid[0] && data_valid[0];

	assign mem_we = commit;
	assign mem_waddr = addr[0];
	assign mem_wdata = data[0];

	assign new_data_ready = issue_data_ready || (cdb_valid && cdb_tag == issue_data_tag);
	assign new_data = issue_data_ready ? issue_data_data : cdb_data;

	always_comb begin
		logic hit;
		for (int j = 0; j < store_depth; j++) begin
			hit = agu_write && agu_is_store && agu_slot == slot_width'(j);
			upd_addr_valid[j] = addr_valid[j] || hit;
			upd_addr[j] = hit ? agu_addr : addr[j];
			upd_data_valid[j] = data_valid[j] || (cdb_valid && cdb_tag == tag[j]);
			upd_data[j] = data_valid[j] ? data[j] : cdb_data;
		end
	end

	// only the stores ahead of the head load matter
	always_comb begin
		older_known = 1'b1;
		fwd_hit = 1'b0;
		fwd_data = '0;
		for (int j = 0; j < store_depth; j++) begin
			if (count_width'(j) < head_older) begin
				if (!(addr_valid[j] && data_valid[j])) begin
					older_known = 1'b0;
				end
				if (addr_valid[j] && addr[j] == head_addr) begin
					fwd_hit = 1'b1;
					fwd_data = data[j]; // youngest match wins
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= ins + count_width'(push);
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < store_depth; j++) begin
			if (push && ins == count_width'(j)) begin
				addr[j] <= issue_imm.abs.addr;
				addr_valid[j] <= issue_absolute;
				data[j] <= new_data;
				data_valid[j] <= new_data_ready;
				tag[j] <= issue_data_tag;
			end else if (commit) begin
				addr[j] <= upd_addr[(j + 1) % store_depth];
				addr_valid[j] <= upd_addr_valid[(j + 1) % store_depth];
				data[j] <= upd_data[(j + 1) % store_depth];
				data_valid[j] <= upd_data_valid[(j + 1) % store_depth];
				tag[j] <= tag[(j + 1) % store_depth];
			end else begin
				addr[j] <= upd_addr[j];
				addr_valid[j] <= upd_addr_valid[j];
				data[j] <= upd_data[j];
				data_valid[j] <= upd_data_valid[j];
			end
		end
	end

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ps

// load_depth is expected not to exceed store_depth
module lsu_top #(
	parameter int load_depth = 2,
	parameter int store_depth = 4
) (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input logic issue_store,
	input logic issue_absolute,
	input lsu_pkg::lsu_imm_u issue_imm,
	input logic issue_base_ready,
	input logic [lsu_pkg::tag_width-1:0] issue_base_tag,
	input logic [lsu_pkg::data_width-1:0] issue_base_data,
	input logic issue_data_ready,
	input logic [lsu_pkg::tag_width-1:0] issue_data_tag,
	input logic [lsu_pkg::data_width-1:0] issue_data_data,
	input logic [lsu_pkg::tag_width-1:0] issue_tag,
	output logic issue_ready,
	input logic cdb_valid,
	input logic [lsu_pkg::tag_width-1:0] cdb_tag,
	input logic [lsu_pkg::data_width-1:0] cdb_data,
	input logic commit,
	output logic store_head_done,
	output logic load_valid,
	input logic load_ready,
	output logic result_valid,
	output logic [lsu_pkg::tag_width-1:0] result_tag,
	output logic [lsu_pkg::data_width-1:0] result_data
);
	localparam int slot_width = $clog2(load_depth > store_depth ? load_depth : store_depth);
	localparam int older_width = $clog2(store_depth + 1);

	logic issue_accept;
	logic agu_full, load_full, store_full;
	logic agu_write, agu_is_store;
	logic [slot_width-1:0] agu_slot, load_next_slot, store_next_slot;
	logic [lsu_pkg::addr_width-1:0] agu_addr, head_addr, mem_waddr;
	logic load_pop, older_known, fwd_hit, mem_we;
	logic [older_width-1:0] head_older, store_count;
	logic [lsu_pkg::data_width-1:0] fwd_data, mem_wdata, mem_rdata;

	// a pop in the same cycle already counts as room
	assign issue_ready = (issue_absolute || !agu_full) && (issue_store || !load_full) &&
		(!issue_store || !store_full);
	assign issue_accept = issue_valid && issue_ready;

	lsu_agu #(.load_depth(load_depth), .store_depth(store_depth)) u_agu (
		.clk, .reset, .issue_accept, .issue_store, .issue_absolute, .issue_imm,
		.issue_base_ready, .issue_base_tag, .issue_base_data,
		.load_next_slot, .store_next_slot, .load_pop, .commit,
		.cdb_valid, .cdb_tag, .cdb_data,
		.agu_full, .agu_write, .agu_is_store, .agu_slot, .agu_addr
	);

	lsu_load_queue #(.load_depth(load_depth), .store_depth(store_depth)) u_load_queue (
		.clk, .reset, .issue_accept, .issue_store, .issue_absolute, .issue_imm, .issue_tag,
		.store_count, .agu_write, .agu_is_store, .agu_slot, .agu_addr,
		.older_known, .fwd_hit, .fwd_data, .commit, .mem_rdata, .load_ready,
		.load_full, .load_next_slot, .load_pop, .head_addr, .head_older,
		.load_valid, .result_valid, .result_tag, .result_data
	);

	lsu_store_queue #(.store_depth(store_depth)) u_store_queue (
		.clk, .reset, .issue_accept, .issue_store, .issue_absolute, .issue_imm,
		.issue_data_ready, .issue_data_tag, .issue_data_data,
		.cdb_valid, .cdb_tag, .cdb_data,
		.agu_write, .agu_is_store, .agu_slot, .agu_addr,
		.commit, .head_addr, .head_older,
		.store_full, .store_count, .store_next_slot, .store_head_done,
		.older_known, .fwd_hit, .fwd_data, .mem_we, .mem_waddr, .mem_wdata
	);

	lsu_data_mem u_data_mem (
		.clk,
		.we(mem_we),
		.waddr(mem_waddr),
		.wdata(mem_wdata),
		.raddr(head_addr),
		.rdata(mem_rdata)
	);

endmodule

// File: verification/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
	localparam int load_depth = 2;
	localparam int store_depth = 4;
	localparam int max_ops = 128;
	localparam int wait_limit = 500;
	localparam int tw = lsu_pkg::tag_width;
	localparam int aw = lsu_pkg::addr_width;

	logic clk = 1'b0;
	logic reset;
	logic issue_valid;
	logic issue_store;
	logic issue_absolute;
	lsu_pkg::lsu_imm_u issue_imm;
	logic issue_base_ready;
	logic [tw-1:0] issue_base_tag;
	logic [31:0] issue_base_data;
	logic issue_data_ready;
	logic [tw-1:0] issue_data_tag;
	logic [31:0] issue_data_data;
	logic [tw-1:0] issue_tag;
	logic issue_ready;
	logic cdb_valid;
	logic [tw-1:0] cdb_tag;
	logic [31:0] cdb_data;
	logic commit;
	logic store_head_done;
	logic load_valid;
	logic load_ready;
	logic result_valid;
	logic [tw-1:0] result_tag;
	logic [31:0] result_data;

	// eight words per operation
	logic [31:0] cases [max_ops*8];

	// every store issued so far, oldest first
	logic [aw-1:0] st_addr [max_ops];
	logic st_addr_known [max_ops];
	logic [tw-1:0] st_base_tag [max_ops];
	logic [15:0] st_off [max_ops];
	logic [31:0] st_data [max_ops];
	logic st_data_known [max_ops];
	logic [tw-1:0] st_data_tag [max_ops];
	int n_st = 0;

	logic [tw-1:0] ld_tag [max_ops];
	logic [aw-1:0] ld_addr [max_ops];
	logic ld_addr_known [max_ops];
	logic [tw-1:0] ld_base_tag [max_ops];
	logic [15:0] ld_off [max_ops];
	int ld_older [max_ops]; // stores issued ahead of the load
	int n_ld = 0;
	int ld_next = 0;

	logic [tw-1:0] got_tag [$];
	logic [31:0] got_data [$];
	int loads_accepted = 0;
	int results_seen = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int test_errors = 0;
	bit timed_out = 1'b0;
	bit popped = 1'b0;
	bit held = 1'b0;

	lsu_top #(.load_depth(load_depth), .store_depth(store_depth)) u_dut (.*);

	always #5 clk = ~clk;

	initial begin
		load_ready = 1'b0;
		void'($urandom(21));
		forever begin
			@(negedge clk);
			load_ready = ($urandom % 4) != 0; // stall about one cycle in four
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			// a taken load returns exactly one cycle later
			compare_value("result_valid", popped, result_valid);
			if (held) begin
				compare_value("load_valid", 1, load_valid); // stays up until taken
			end
			if (result_valid === 1'b1) begin
				if (results_seen >= loads_accepted) begin
					errors++;
					$display("result_valid went high with no accepted load waiting for it");
				end
				results_seen++;
				got_tag.push_back(result_tag);
				got_data.push_back(result_data);
			end
			if (issue_valid && issue_ready && !issue_store) begin
				loads_accepted++;
			end
			popped = load_valid && load_ready;
			held = load_valid && !load_ready;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: %s expected %h got %h", name, expected, actual);
		end
	endtask

	function automatic logic [aw-1:0] offset_addr(input logic [31:0] base, input logic [15:0] off);
		int unsigned word;
		word = base + int'($signed(off)); // offset is two's complement
		return aw'(word);
	endfunction

	task automatic check_reset_state();
		compare_value("issue_ready", 1, issue_ready);
		compare_value("load_valid", 0, load_valid);
		compare_value("result_valid", 0, result_valid);
		compare_value("store_head_done", 0, store_head_done);
	endtask

	task automatic issue_instruction(input int p);
		logic [31:0] flags;
		logic [15:0] imm;
		logic accepted;
		int n;
		flags = cases[p+1];
		imm = cases[p+2][15:0];
		issue_valid = 1'b1;
		issue_store = flags[0];
		issue_absolute = flags[1];
		issue_base_ready = flags[2];
		issue_data_ready = flags[3];
		issue_imm = imm;
		issue_base_tag = cases[p+3][tw-1:0];
		issue_base_data = cases[p+4];
		issue_data_tag = cases[p+5][tw-1:0];
		issue_data_data = cases[p+6];
		issue_tag = cases[p+7][tw-1:0];
		accepted = 1'b0;
		n = 0;
		while (!accepted && n < wait_limit) begin
			@(posedge clk);
			accepted = issue_ready;
			n++;
		end
		@(negedge clk);
		issue_valid = 1'b0;
		if (!accepted) begin
			$display("timeout: instruction on case line %0d was never accepted", p / 8);
			timed_out = 1'b1;
			return;
		end
		if (flags[0]) begin
			st_addr_known[n_st] = flags[1] || flags[2];
			st_addr[n_st] = flags[1] ? imm[aw-1:0] : offset_addr(cases[p+4], imm);
			st_base_tag[n_st] = cases[p+3][tw-1:0];
			st_off[n_st] = imm;
			st_data_known[n_st] = flags[3];
			st_data[n_st] = cases[p+6];
			st_data_tag[n_st] = cases[p+5][tw-1:0];
			n_st++;
		end else begin
			ld_addr_known[n_ld] = flags[1] || flags[2];
			ld_addr[n_ld] = flags[1] ? imm[aw-1:0] : offset_addr(cases[p+4], imm);
			ld_base_tag[n_ld] = cases[p+3][tw-1:0];
			ld_off[n_ld] = imm;
			ld_tag[n_ld] = cases[p+7][tw-1:0];
			ld_older[n_ld] = n_st;
			n_ld++;
		end
	endtask

	task automatic broadcast_cdb(input int p);
		logic [tw-1:0] t;
		logic [31:0] v;
		t = cases[p+3][tw-1:0];
		v = cases[p+4];
		cdb_valid = 1'b1;
		cdb_tag = t;
		cdb_data = v;
		@(negedge clk);
		cdb_valid = 1'b0;
		for (int j = 0; j < n_st; j++) begin
			if (!st_addr_known[j] && st_base_tag[j] == t) begin
				st_addr[j] = offset_addr(v, st_off[j]);
				st_addr_known[j] = 1'b1;
			end
			if (!st_data_known[j] && st_data_tag[j] == t) begin
				st_data[j] = v;
				st_data_known[j] = 1'b1;
			end
		end
		for (int j = 0; j < n_ld; j++) begin
			if (!ld_addr_known[j] && ld_base_tag[j] == t) begin
				ld_addr[j] = offset_addr(v, ld_off[j]);
				ld_addr_known[j] = 1'b1;
			end
		end
	endtask

	task automatic commit_store();
		int n;
		n = 0;
		while (store_head_done !== 1'b1 && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (store_head_done !== 1'b1) begin
			$display("timeout: the oldest store never got both address and data");
			timed_out = 1'b1;
			return;
		end
		commit = 1'b1;
		@(negedge clk);
		commit = 1'b0;
	endtask

	task automatic check_load_result();
		logic [31:0] expected;
		logic known;
		logic found;
		int n;
		n = 0;
		while (got_tag.size() == 0 && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (got_tag.size() == 0) begin
			$display("timeout: no load result arrived");
			timed_out = 1'b1;
			return;
		end
		if (ld_next >= n_ld) begin
			errors++;
			$display("a load result was expected but no load was issued for it");
			return;
		end
		// youngest older store to the same word, else memory, zero if never written
		known = ld_addr_known[ld_next];
		found = 1'b0;
		expected = '0;
		for (int j = ld_older[ld_next] - 1; j >= 0 && !found; j--) begin
			if (!st_addr_known[j]) begin
				known = 1'b0;
			end else if (st_addr[j] == ld_addr[ld_next]) begin
				found = 1'b1;
				expected = st_data[j];
				known = known && st_data_known[j];
			end
		end
		if (!known) begin
			errors++;
			$display("the expected value of load %0d cannot be worked out", ld_next);
		end
		compare_value("result_tag", ld_tag[ld_next], got_tag.pop_front());
		compare_value("result_data", expected, got_data.pop_front());
		ld_next++;
	endtask

	task automatic check_issue_ready(input int p);
		issue_store = 1'b1;
		issue_absolute = 1'b1;
		@(posedge clk);
		compare_value("issue_ready", cases[p+4], issue_ready);
		@(negedge clk);
	endtask

	task automatic check_no_result(input int p);
		for (int n = 0; n < cases[p+2]; n++) begin
			@(negedge clk);
		end
		compare_value("result_valid", 0, got_tag.size());
	endtask

	task automatic end_test(input int p);
		tests++;
		if (errors == test_errors) begin
			$display("test %0d ok", cases[p+2]);
		end else begin
			$display("test %0d failed with %0d errors", cases[p+2], errors - test_errors);
		end
		test_errors = errors;
	endtask

	initial begin
		int p;
		logic [31:0] op;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_store = 1'b0;
		issue_absolute = 1'b0;
		issue_imm = '0;
		issue_base_ready = 1'b0;
		issue_base_tag = '0;
		issue_base_data = '0;
		issue_data_ready = 1'b0;
		issue_data_tag = '0;
		issue_data_data = '0;
		issue_tag = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		commit = 1'b0;
		$readmemh("verification/lsu_cases.txt", cases);
		repeat (8) @(negedge clk);
		reset = 1'b0;
		check_reset_state();

		p = 0;
		op = cases[0];
		while (op !== 32'h0 && !timed_out && p < max_ops * 8) begin
			case (op)
				32'h1: issue_instruction(p);
				32'h2: broadcast_cdb(p);
				32'h3: commit_store();
				32'h4: check_load_result();
				32'h5: check_issue_ready(p);
				32'h6: end_test(p);
				32'h7: check_no_result(p);
				default: begin
					errors++;
					$display("unknown operation %h on case line %0d", op, p / 8);
				end
			endcase
			p += 8;
			op = (p < max_ops * 8) ? cases[p] : 32'h0;
		end

		if (!timed_out && got_tag.size() != 0) begin
			errors++;
			$display("%0d load results arrived that no case expected", got_tag.size());
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (timed_out || errors != 0) begin
			$display("Simulation FAILED");
		end else begin
			$display("Simulation PASSED");
		end
		$finish;
	end

endmodule

// File: verification/lsu_cases.txt
// op flags imm base_tag base_data data_tag data_data load_tag
// op 1 issue, 2 cdb, 3 commit, 4 load result, 5 issue_ready, 6 test end, 7 quiet cycles
// flags bit0 store, bit1 absolute, bit2 base ready, bit3 data ready
1 2 0010 0 0 0 0 1
4 0 0 0 0 0 0 0
1 2 03ff 0 0 0 0 2
4 0 0 0 0 0 0 0
1 b 0010 0 0 0 cafe0001 0
1 b 0020 0 0 0 cafe0002 0
3 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
1 2 0010 0 0 0 0 3
1 2 0020 0 0 0 0 4
4 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0
6 0 1 0 0 0 0 0
// forwarding, youngest of two matching stores
1 b 0030 0 0 0 11111111 0
1 2 0030 0 0 0 0 5
4 0 0 0 0 0 0 0
1 b 0030 0 0 0 22222222 0
1 b 0040 0 0 0 33333333 0
1 2 0030 0 0 0 0 6
4 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
6 0 2 0 0 0 0 0
// pending store data, then pending store base
1 3 0050 0 0 7 0 0
1 2 0050 0 0 0 0 8
7 0 a 0 0 0 0 0
2 0 0 7 77770000 0 0 0
4 0 0 0 0 0 0 0
1 9 0004 9 0 0 99990000 0
1 2 0060 0 0 0 0 a
7 0 a 0 0 0 0 0
2 0 0 9 0000005c 0 0 0
4 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
6 0 3 0 0 0 0 0
// negative offsets
1 b 0100 0 0 0 44440000 0
3 0 0 0 0 0 0 0
1 4 fff0 0 00000110 0 0 b
4 0 0 0 0 0 0 0
1 d fff8 0 00000208 0 55550000 0
1 2 0200 0 0 0 0 c
4 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
6 0 4 0 0 0 0 0
// back to back loads under load_ready stalls
1 2 0010 0 0 0 0 d
1 2 0020 0 0 0 0 e
1 2 0030 0 0 0 0 f
1 2 0100 0 0 0 0 1
1 0 0000 2 0 0 0 2
2 0 0 2 00000040 0 0 0
4 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0
6 0 5 0 0 0 0 0
// full store queue
1 b 0300 0 0 0 60000000 0
1 b 0301 0 0 0 60000001 0
1 b 0302 0 0 0 60000002 0
1 b 0303 0 0 0 60000003 0
5 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
5 0 0 0 1 0 0 0
1 b 0304 0 0 0 60000004 0
1 2 0303 0 0 0 0 3
1 2 0304 0 0 0 0 4
4 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0
6 0 6 0 0 0 0 0
0 0 0 0 0 0 0 0

// File: tb.f
source/lsu_pkg.sv
source/lsu_data_mem.sv
source/lsu_agu.sv
source/lsu_load_queue.sv
source/lsu_store_queue.sv
source/lsu_top.sv
verification/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - source/lsu_pkg.sv
  - source/lsu_data_mem.sv
  - source/lsu_agu.sv
  - source/lsu_load_queue.sv
  - source/lsu_store_queue.sv
  - source/lsu_top.sv
  - target: test
    files:
      - verification/lsu_tb.sv
